// ==== verilog/fifo_cfg_pkg.sv ====
/*
 * FIFO configuration
 * Storage geometry and data word type shared by the dual-clock FIFO
 * and its testbench
 */

package fifo_cfg_pkg;

	// --------------------------------------------------
	// Geometry
	// --------------------------------------------------
	localparam int ADDR_WIDTH	= 5;				// RAM address bits
	localparam int DATA_WIDTH	= 8;				// Stored word width
	localparam int DEPTH		= 1 << ADDR_WIDTH;	// Entries, 32 for a 5-bit address

	// Pointers carry one extra wrap bit above ADDR_WIDTH,
	// so full and empty stay distinguishable at equal addresses

	// --------------------------------------------------
	// Data type
	// --------------------------------------------------
	typedef logic [DATA_WIDTH-1:0] fifo_data_t;		// One stored word

endpackage

// ==== verilog/fifo_ptr_pkg.sv ====
/*
 * FIFO pointer definitions
 * Pointer word read either as a binary count or as wrap bit plus
 * RAM address, and the binary/Gray conversions used for crossing
 */

package fifo_ptr_pkg;

	// --------------------------------------------------
	// Pointer word
	// --------------------------------------------------
	typedef union packed {
		logic [fifo_cfg_pkg::ADDR_WIDTH:0]	count;		// Plain count, for increment
		struct packed {
			logic								wrap;	// Lap bit, toggles per pass
			logic [fifo_cfg_pkg::ADDR_WIDTH-1:0]	addr;	// RAM location
		} fld;
	} ptr_t;

	// --------------------------------------------------
	// Gray conversions
	// --------------------------------------------------
	function automatic ptr_t bin_to_gray(input ptr_t bin);
		ptr_t gray;
		gray.count = bin.count ^ (bin.count >> 1);		// Adjacent bits XORed
		return gray;
	endfunction

	function automatic ptr_t gray_to_bin(input ptr_t gray);
		ptr_t bin;
		bin.count[fifo_cfg_pkg::ADDR_WIDTH] = gray.count[fifo_cfg_pkg::ADDR_WIDTH];	// MSB kept
		for (int i = fifo_cfg_pkg::ADDR_WIDTH - 1; i >= 0; i--) begin
			bin.count[i] = bin.count[i+1] ^ gray.count[i];	// Running XOR from top
		end
		return bin;
	endfunction

endpackage

// ==== verilog/dpram_dist.sv ====
/*
 * Distributed dual-port RAM
 * One synchronous write port on clk_wr and one asynchronous read
 * port, as in LUT RAM. Read address is driven from the read domain
 */

`timescale 1ns/1ps

module dpram_dist #(
	parameter int	DATA_WIDTH	= 8,	// Word width
	parameter int	ADDR_WIDTH	= 5		// Address bits, depth is 2**ADDR_WIDTH
) (
	// --------------------------------------------------
	// Write port
	// --------------------------------------------------
	input	logic					clk_wr,		// Write clock
	input	logic					wr_en,		// Write strobe, already qualified
	input	logic [ADDR_WIDTH-1:0]	wr_addr,	// Write location
	input	logic [DATA_WIDTH-1:0]	din,		// Write data
	// --------------------------------------------------
	// Read port
	// --------------------------------------------------
	input	logic [ADDR_WIDTH-1:0]	rd_addr,	// Read location, from read domain
	output	logic [DATA_WIDTH-1:0]	dout		// Read data, no clock
);

	// Storage array
	// Starts cleared, same as an all-zero LUT RAM INIT
	logic [DATA_WIDTH-1:0] mem [0:(1<<ADDR_WIDTH)-1] = '{default: '0};

	// --------------------------------------------------
	// Write
	// --------------------------------------------------
	always_ff @(posedge clk_wr) begin
		if (wr_en) begin
			mem[wr_addr] <= din;	// Single write per edge
		end
	end

	// --------------------------------------------------
	// Read
	// --------------------------------------------------
	// Combinational lookup, new data as soon as rd_addr moves.
	// No output register, so the FIFO sees zero read latency
	assign dout = mem[rd_addr];		// Async read port

endmodule

// ==== verilog/ptr_sync.sv ====
/*
 * Gray pointer synchronizer
 * Two flop stages in the destination clock. Input is Gray coded,
 * so at most one bit is in flight per source step
 */

`timescale 1ns/1ps

module ptr_sync (
	input	logic					clk,		// Destination clock
	input	logic					reset,		// Sync reset, active high
	input	fifo_ptr_pkg::ptr_t		gray_in,	// Gray pointer from other domain
	output	fifo_ptr_pkg::ptr_t		gray_out	// Gray pointer, now local
);

	fifo_ptr_pkg::ptr_t sync_meta;		// First stage, may go metastable

	// --------------------------------------------------
	// Two-stage capture
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			sync_meta	<= '0;			// Both stages cleared
			gray_out	<= '0;
		end else begin
			sync_meta	<= gray_in;		// Capture foreign value
			gray_out	<= sync_meta;	// Settled copy
		end
	end

endmodule

// ==== verilog/fifo_wr_ctrl.sv ====
/*
 * FIFO write controller
 * Binary and Gray write pointers, registered full flag and overflow
 * pulse, all in the clk_wr domain
 */

`timescale 1ns/1ps

module fifo_wr_ctrl (
	input	logic								clk_wr,			// Write clock
	input	logic								reset,			// Sync reset, active high
	input	logic								wr_en,			// Write request
	input	fifo_ptr_pkg::ptr_t					rd_gray_sync,	// Read pointer, synchronized
	output	logic								ram_we,			// Accepted write
	output	logic [fifo_cfg_pkg::ADDR_WIDTH-1:0]	wr_addr,		// RAM write location
	output	fifo_ptr_pkg::ptr_t					wr_gray,		// Gray pointer to cross
	output	logic								full,			// No room left
	output	logic								overflow		// Dropped write, one cycle
);

	fifo_ptr_pkg::ptr_t	wr_bin;			// Binary write pointer
	fifo_ptr_pkg::ptr_t	wr_bin_next;	// After this edge
	fifo_ptr_pkg::ptr_t	wr_gray_next;	// Gray of next pointer
	logic				full_next;		// Full after this edge

	// --------------------------------------------------
	// Next pointer and full detection
	// --------------------------------------------------
	assign ram_we	= wr_en & ~full;		// Drop writes while full
	assign wr_addr	= wr_bin.fld.addr;		// Address field only

	always_comb begin
		wr_bin_next = wr_bin;
		if (ram_we) begin
			wr_bin_next.count = wr_bin.count + 1'b1;	// Count view for increment
		end
		wr_gray_next = fifo_ptr_pkg::bin_to_gray(wr_bin_next);
		// Full when one lap ahead of the reader.
		// In Gray that means wrap and address MSB differ, the rest match
		full_next =
			(wr_gray_next.fld.wrap != rd_gray_sync.fld.wrap) &&
			(wr_gray_next.fld.addr[fifo_cfg_pkg::ADDR_WIDTH-1] !=
				rd_gray_sync.fld.addr[fifo_cfg_pkg::ADDR_WIDTH-1]) &&
			(wr_gray_next.fld.addr[fifo_cfg_pkg::ADDR_WIDTH-2:0] ==
				rd_gray_sync.fld.addr[fifo_cfg_pkg::ADDR_WIDTH-2:0]);
	end

	// --------------------------------------------------
	// State registers
	// --------------------------------------------------
	always_ff @(posedge clk_wr) begin
		if (reset) begin
			wr_bin		<= '0;
			wr_gray		<= '0;
			full		<= 1'b0;
			overflow	<= 1'b0;
		end else begin
			wr_bin		<= wr_bin_next;
			wr_gray		<= wr_gray_next;	// Registered, glitch-free crossing
			full		<= full_next;		// Rises on the filling write
			overflow	<= wr_en & full;	// Write attempt while full
		end
	end

endmodule

// ==== verilog/fifo_rd_ctrl.sv ====
/*
 * FIFO read controller
 * Binary and Gray read pointers, registered empty flag and underflow
 * pulse in the clk_rd domain. Output is first-word-fall-through
 */

`timescale 1ns/1ps

module fifo_rd_ctrl (
	input	logic								clk_rd,			// Read clock
	input	logic								reset,			// Sync reset, active high
	input	logic								rd_en,			// Read request
	input	fifo_ptr_pkg::ptr_t					wr_gray_sync,	// Write pointer, synchronized
	output	logic [fifo_cfg_pkg::ADDR_WIDTH-1:0]	rd_addr,		// RAM read location
	output	fifo_ptr_pkg::ptr_t					rd_gray,		// Gray pointer to cross
	output	logic								empty,			// Nothing visible
	output	logic								underflow		// Dropped read, one cycle
);

	fifo_ptr_pkg::ptr_t	rd_bin;			// Binary read pointer
	fifo_ptr_pkg::ptr_t	rd_bin_next;	// After this edge
	fifo_ptr_pkg::ptr_t	rd_gray_next;	// Gray of next pointer
	logic				rd_take;		// Accepted read
	logic				empty_next;		// Empty after this edge

	// --------------------------------------------------
	// Next pointer and empty detection
	// --------------------------------------------------
	assign rd_take	= rd_en & ~empty;		// Ignore reads while empty

	// Pointer names the word handed out next. RAM read is async,
	// so dout already holds it and moves on with the pointer
	assign rd_addr	= rd_bin.fld.addr;

	always_comb begin
		rd_bin_next = rd_bin;
		if (rd_take) begin
			rd_bin_next.count = rd_bin.count + 1'b1;	// Count view for increment
		end
		rd_gray_next	= fifo_ptr_pkg::bin_to_gray(rd_bin_next);
		empty_next		= (rd_gray_next == wr_gray_sync);	// Caught up with writer
	end

	// --------------------------------------------------
	// State registers
	// --------------------------------------------------
	always_ff @(posedge clk_rd) begin
		if (reset) begin
			rd_bin		<= '0;
			rd_gray		<= '0;
			empty		<= 1'b1;			// Nothing stored yet
			underflow	<= 1'b0;
		end else begin
			rd_bin		<= rd_bin_next;
			rd_gray		<= rd_gray_next;	// Registered, glitch-free crossing
			empty		<= empty_next;		// Rises on the last read
			underflow	<= rd_en & empty;	// Read attempt while empty
		end
	end

endmodule

// ==== verilog/async_fifo_dist.sv ====
/*
 * Dual-clock FIFO on distributed RAM
 * Write and read controllers, Gray pointer synchronizers both ways
 * and a LUT-style dual-port RAM. First-word-fall-through read side
 */

`timescale 1ns/1ps

module async_fifo_dist (
	input	logic						clk_wr,		// Write clock
	input	logic						clk_rd,		// Read clock
	input	logic						reset,		// Sync reset, both domains
	input	logic						wr_en,		// Write strobe
	input	fifo_cfg_pkg::fifo_data_t	din,		// Write data
	input	logic						rd_en,		// Read strobe
	output	fifo_cfg_pkg::fifo_data_t	dout,		// Oldest word while not empty
	output	logic						full,		// Write side flag
	output	logic						empty,		// Read side flag
	output	logic						overflow,	// Write dropped
	output	logic						underflow	// Read dropped
);

	logic								ram_we;			// Qualified write
	logic [fifo_cfg_pkg::ADDR_WIDTH-1:0]	wr_addr;
	logic [fifo_cfg_pkg::ADDR_WIDTH-1:0]	rd_addr;
	fifo_ptr_pkg::ptr_t					wr_gray;		// clk_wr domain
	fifo_ptr_pkg::ptr_t					rd_gray;		// clk_rd domain
	fifo_ptr_pkg::ptr_t					wr_gray_sync;	// Write ptr seen by reader
	fifo_ptr_pkg::ptr_t					rd_gray_sync;	// Read ptr seen by writer

	// --------------------------------------------------
	// Storage
	// --------------------------------------------------
	dpram_dist #(
		.DATA_WIDTH	(fifo_cfg_pkg::DATA_WIDTH),
		.ADDR_WIDTH	(fifo_cfg_pkg::ADDR_WIDTH)
	) u_ram (
		.clk_wr		(clk_wr),
		.wr_en		(ram_we),
		.wr_addr	(wr_addr),
		.din		(din),
		.rd_addr	(rd_addr),
		.dout		(dout)
	);

	// --------------------------------------------------
	// Controllers and crossings
	// --------------------------------------------------
	fifo_wr_ctrl u_wr_ctrl (
		.clk_wr			(clk_wr),
		.reset			(reset),
		.wr_en			(wr_en),
		.rd_gray_sync	(rd_gray_sync),
		.ram_we			(ram_we),
		.wr_addr		(wr_addr),
		.wr_gray		(wr_gray),
		.full			(full),
		.overflow		(overflow)
	);

	fifo_rd_ctrl u_rd_ctrl (
		.clk_rd			(clk_rd),
		.reset			(reset),
		.rd_en			(rd_en),
		.wr_gray_sync	(wr_gray_sync),
		.rd_addr		(rd_addr),
		.rd_gray		(rd_gray),
		.empty			(empty),
		.underflow		(underflow)
	);

	ptr_sync u_wr2rd (.clk(clk_rd), .reset(reset), .gray_in(wr_gray), .gray_out(wr_gray_sync));
	ptr_sync u_rd2wr (.clk(clk_wr), .reset(reset), .gray_in(rd_gray), .gray_out(rd_gray_sync));

endmodule

// ==== test/async_fifo_dist_sva.sv ====
/*
 * Dual-clock FIFO assertions
 * Full rising only on an accepted write, Gray pointer steps on both
 * sides of each synchronizer, dropped writes holding the pointer
 */

`timescale 1ns/1ps

module async_fifo_dist_sva (
	input	logic					clk_wr,
	input	logic					clk_rd,
	input	logic					reset,
	input	logic					ram_we,
	input	logic					full,
	input	logic					overflow,
	input	fifo_ptr_pkg::ptr_t		wr_gray,
	input	fifo_ptr_pkg::ptr_t		rd_gray,
	input	fifo_ptr_pkg::ptr_t		wr_gray_sync,
	input	fifo_ptr_pkg::ptr_t		rd_gray_sync
);

	// --------------------------------------------------
	// Write side
	// --------------------------------------------------
	// Reader only moves away, so full can only come from a write
	a_full_on_write: assert property (@(posedge clk_wr) disable iff (reset)
		$rose(full) |-> $past(ram_we)) else $error("full rose without an accepted write");

	a_overflow_drop: assert property (@(posedge clk_wr) disable iff (reset)
		overflow |-> $stable(wr_gray)) else $error("dropped write moved the write pointer");

	// --------------------------------------------------
	// Gray steps
	// --------------------------------------------------
	a_wr_gray_step: assert property (@(posedge clk_wr) disable iff (reset)
		$countones(wr_gray.count ^ $past(wr_gray.count)) <= 1) else $error("wr_gray not Gray");

	a_rd_gray_step: assert property (@(posedge clk_rd) disable iff (reset)
		$countones(rd_gray.count ^ $past(rd_gray.count)) <= 1) else $error("rd_gray not Gray");

	a_rd_sync_step: assert property (@(posedge clk_wr) disable iff (reset)
		$countones(rd_gray_sync.count ^ $past(rd_gray_sync.count)) <= 1)
		else $error("rd_gray_sync jumped more than one bit");

	// Faster writer, up to two steps fit in one clk_rd period
	a_wr_sync_step: assert property (@(posedge clk_rd) disable iff (reset)
		$countones(wr_gray_sync.count ^ $past(wr_gray_sync.count)) <= 2)
		else $error("wr_gray_sync jumped more than two bits");

endmodule

bind async_fifo_dist async_fifo_dist_sva u_sva (
	.clk_wr			(clk_wr),
	.clk_rd			(clk_rd),
	.reset			(reset),
	.ram_we			(ram_we),
	.full			(full),
	.overflow		(overflow),
	.wr_gray		(wr_gray),
	.rd_gray		(rd_gray),
	.wr_gray_sync	(wr_gray_sync),
	.rd_gray_sync	(rd_gray_sync)
);

// ==== test/async_fifo_dist_tb.sv ====
/*
 * Dual-clock FIFO testbench
 * Drifting clocks, xorshift stimulus on both sides, a queue model of
 * the stored words, directed fill/drain/recovery tests and a summary
 */

`timescale 1ns/1ps

module async_fifo_dist_tb;

	localparam int			TIMEOUT			= 64;			// Cycles allowed per flag wait
	localparam int			RAND_WR_CYCLES	= 2000;			// Random run, clk_wr cycles
	localparam int			RAND_RD_CYCLES	= 1430;			// Same span in clk_rd cycles
	localparam logic [31:0]	SEED			= 32'h6ec96a40;

	logic						clk_wr;
	logic						clk_rd;
	logic						reset;
	logic						wr_en;
	logic						rd_en;
	fifo_cfg_pkg::fifo_data_t	din;
	fifo_cfg_pkg::fifo_data_t	dout;
	logic						full;
	logic						empty;
	logic						overflow;
	logic						underflow;

	fifo_cfg_pkg::fifo_data_t	model [$];		// Words written and not yet read
	int							errors;
	int							tests_passed;
	int							tests_failed;
	logic [31:0]				wr_rng;			// Write side generator state
	logic [31:0]				rd_rng;			// Read side, separate stream

	async_fifo_dist uut (
		.clk_wr		(clk_wr),
		.clk_rd		(clk_rd),
		.reset		(reset),
		.wr_en		(wr_en),
		.din		(din),
		.rd_en		(rd_en),
		.dout		(dout),
		.full		(full),
		.empty		(empty),
		.overflow	(overflow),
		.underflow	(underflow)
	);

	always #5 clk_wr = ~clk_wr;		// 10 ns
	always #7 clk_rd = ~clk_rd;		// 14 ns, drifts against clk_wr

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_data(input string name, input fifo_cfg_pkg::fifo_data_t expected,
			input fifo_cfg_pkg::fifo_data_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s expected %02h actual %02h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s expected %b actual %b", name, expected, actual);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			tests_passed++;
			$display("PASS %s", name);
		end else begin
			tests_failed++;
			$display("FAIL %s", name);
		end
	endtask

	// One write slot, outputs show its edge on return
	task automatic wr_cycle(input logic en, input fifo_cfg_pkg::fifo_data_t data);
		@(posedge clk_wr);
		#1;
		wr_en	= en;
		din		= data;
		if (en && !full) begin
			model.push_back(data);		// Accepted at the coming edge
		end
		@(posedge clk_wr);
		#1;
		wr_en	= 1'b0;
	endtask

	// One read slot, dout checked before the consuming edge
	task automatic rd_cycle(input string name, input logic en);
		logic take;
		@(posedge clk_rd);
		#1;
		take = en && !empty;
		if (take) begin
			if (model.size() == 0) begin
				$display("%s: DUT offered a word that was never written", name);
				errors++;
			end else begin
				check_data(name, model.pop_front(), dout);
			end
		end
		rd_en = en;
		@(posedge clk_rd);
		#1;
		rd_en = 1'b0;
		if (take && model.size() == 0) begin
			check_flag({name, " empty"}, 1'b1, empty);	// Last word gone, same edge
		end
	endtask

	task automatic wait_empty_low(input string name);
		int n;
		n = 0;
		while (empty && n < TIMEOUT) begin
			@(posedge clk_rd);
			#1;
			n++;
		end
		if (empty) begin
			$display("%s: empty did not fall within the timeout", name);
			errors++;
		end
	endtask

	task automatic wait_full_low(input string name);
		int n;
		n = 0;
		while (full && n < TIMEOUT) begin
			@(posedge clk_wr);
			#1;
			n++;
		end
		if (full) begin
			$display("%s: full did not fall within the timeout", name);
			errors++;
		end
	endtask

	// Let both Gray pointers finish crossing
	task automatic settle_sync();
		repeat (4) @(posedge clk_wr);
		repeat (4) @(posedge clk_rd);
		#1;
	endtask

	task automatic drain_all(input string name);
		int k;
		for (k = 0; k < 2 * fifo_cfg_pkg::DEPTH && model.size() > 0; k++) begin
			wait_empty_low(name);
			rd_cycle(name, 1'b1);
		end
		if (model.size() != 0) begin
			$display("%s: FIFO still holds words after the drain", name);
			errors++;
		end
	endtask

	// --------------------------------------------------
	// Random traffic, one process per clock domain
	// --------------------------------------------------
	task automatic random_writer();
		int i;
		@(posedge clk_wr);
		#1;
		for (i = 0; i < RAND_WR_CYCLES; i++) begin
			wr_rng	= xorshift32(wr_rng);
			wr_en	= wr_rng[0];					// About half the cycles
			din		= wr_rng[15:8];
			if (wr_en && !full) begin
				model.push_back(din);
			end
			@(posedge clk_wr);
			#1;
		end
		wr_en = 1'b0;
	endtask

	task automatic random_reader();
		int i;
		@(posedge clk_rd);
		#1;
		for (i = 0; i < RAND_RD_CYCLES; i++) begin
			rd_rng	= xorshift32(rd_rng);
			// Eager reader first, then slow so the FIFO fills up
			rd_en	= (i < RAND_RD_CYCLES / 2) ? (rd_rng[1:0] != 2'b00) : (rd_rng[1:0] == 2'b00);
			if (model.size() == 0) begin
				check_flag("random_ordering empty", 1'b1, empty);
			end
			if (rd_en && !empty) begin
				if (model.size() == 0) begin
					$display("random_ordering: read accepted with no word written");
					errors++;
				end else begin
					check_data("random_ordering", model.pop_front(), dout);
				end
			end
			@(posedge clk_rd);
			#1;
		end
		rd_en = 1'b0;
	endtask

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial begin
		int							e0;
		int							i;
		fifo_cfg_pkg::fifo_data_t	word;
		clk_wr			= 1'b0;
		clk_rd			= 1'b0;
		reset			= 1'b1;
		wr_en			= 1'b0;
		rd_en			= 1'b0;
		din				= '0;
		errors			= 0;
		tests_passed	= 0;
		tests_failed	= 0;
		wr_rng			= SEED;
		rd_rng			= ~SEED;

		e0 = errors;
		repeat (5) @(posedge clk_rd);				// Slower clock, covers clk_wr too
		#1;
		reset = 1'b0;
		check_flag("reset_state empty", 1'b1, empty);
		check_flag("reset_state full", 1'b0, full);
		check_flag("reset_state overflow", 1'b0, overflow);
		check_flag("reset_state underflow", 1'b0, underflow);
		report_test("reset_state", e0);

		e0 = errors;
		fork
			random_writer();
			random_reader();
		join
		drain_all("random_ordering drain");
		settle_sync();
		report_test("random_ordering", e0);

		e0 = errors;
		for (i = 0; i < fifo_cfg_pkg::DEPTH; i++) begin
			wr_rng = xorshift32(wr_rng);
			wr_cycle(1'b1, wr_rng[7:0]);
			check_flag("fill_to_full full", i == fifo_cfg_pkg::DEPTH - 1, full);
		end
		wr_cycle(1'b1, 8'hee);						// Dropped, never in the model
		check_flag("fill_to_full overflow", 1'b1, overflow);
		check_flag("fill_to_full still full", 1'b1, full);
		@(posedge clk_wr);
		#1;
		check_flag("fill_to_full overflow pulse", 1'b0, overflow);
		report_test("fill_to_full", e0);

		e0 = errors;
		drain_all("drain_to_empty");
		check_flag("drain_to_empty empty", 1'b1, empty);
		rd_cycle("drain_to_empty extra read", 1'b1);
		check_flag("drain_to_empty underflow", 1'b1, underflow);
		@(posedge clk_rd);
		#1;
		check_flag("drain_to_empty underflow pulse", 1'b0, underflow);
		report_test("drain_to_empty", e0);

		e0 = errors;
		settle_sync();
		wr_rng	= xorshift32(wr_rng);
		word	= wr_rng[7:0];
		wr_cycle(1'b1, word);
		wait_empty_low("flag_recovery empty");
		check_data("flag_recovery dout", word, dout);
		rd_cycle("flag_recovery single read", 1'b1);
		settle_sync();
		for (i = 0; i < fifo_cfg_pkg::DEPTH; i++) begin
			wr_rng = xorshift32(wr_rng);
			wr_cycle(1'b1, wr_rng[7:0]);
		end
		check_flag("flag_recovery full", 1'b1, full);
		rd_cycle("flag_recovery read at full", 1'b1);
		wait_full_low("flag_recovery full");
		drain_all("flag_recovery drain");
		report_test("flag_recovery", e0);

		$display("Tests passed %0d, tests failed %0d, check errors %0d",
			tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
verilog/fifo_cfg_pkg.sv
verilog/fifo_ptr_pkg.sv
verilog/dpram_dist.sv
verilog/ptr_sync.sv
verilog/fifo_wr_ctrl.sv
verilog/fifo_rd_ctrl.sv
verilog/async_fifo_dist.sv
test/async_fifo_dist_sva.sv
test/async_fifo_dist_tb.sv

// ==== Bender.yml ====
package:
  name: async_fifo_dist

sources:
  # Packages first, the RTL refers to them by scoped names
  - verilog/fifo_cfg_pkg.sv
  - verilog/fifo_ptr_pkg.sv
  - verilog/dpram_dist.sv
  - verilog/ptr_sync.sv
  - verilog/fifo_wr_ctrl.sv
  - verilog/fifo_rd_ctrl.sv
  - verilog/async_fifo_dist.sv

  - target: test
    files:
      - test/async_fifo_dist_sva.sv
      - test/async_fifo_dist_tb.sv
